//--- common/capture_pkg.sv
package capture_pkg;

	// One converter sample as delivered by the source
	typedef logic [15:0] sample_t;

	// Default RAM address width, 1024 samples
	parameter int unsigned DEPTH_LOG2 = 10;

	// Capture sequencing
	typedef enum logic [1:0] {
		IDLE = 2'd0, // Waiting for the first start
		RUN  = 2'd1, // Samples are being taken
		DONE = 2'd2  // Buffer full, results held
	} capture_state_e;

endpackage

//--- common/tlul_lite_pkg.sv
package tlul_lite_pkg;

	// Bus word width, the RAM is organised in words of this size
	parameter int unsigned BUS_DW = 32;

	// A channel and D channel opcodes share one type
	// D channel codes are moved off the A channel values so that all stay distinct
	typedef enum logic [2:0] {
		PUT_FULL        = 3'd0,
		PUT_PARTIAL     = 3'd1,
		ACCESS_ACK      = 3'd2,
		ACCESS_ACK_DATA = 3'd3,
		GET             = 3'd4
	} tl_opcode_e;

	// Host to device
	typedef struct packed {
		logic                a_valid;
		tl_opcode_e          a_opcode;
		logic [31:0]         a_address; // Byte address
		logic [BUS_DW/8-1:0] a_mask;
		logic [BUS_DW-1:0]   a_data;
		logic                d_ready;
	} tl_h2d_t;

	// Device to host
	typedef struct packed {
		logic              a_ready;
		logic              d_valid;
		tl_opcode_e        d_opcode;
		logic [BUS_DW-1:0] d_data;
	} tl_d2h_t;

endpackage

//--- source/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl
	import capture_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_ni,
	input  logic           start_i,
	input  logic           take_i,
	input  logic           last_i,
	output logic           clear_o,
	output logic           run_o,
	output logic           done_o,
	output capture_state_e state_o
);

	capture_state_e state_q, state_d;

	// Next state
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (start_i) state_d = RUN;
			end
			RUN: begin
				if (start_i) begin
					state_d = RUN; // Restart from address 0
				end else if (take_i && last_i) begin
					state_d = DONE; // Final address written this cycle
				end
			end
			DONE: begin
				if (start_i) state_d = RUN;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Counters are zeroed on the same edge that enters RUN
	assign clear_o = start_i;

	assign run_o   = (state_q == RUN);
	assign done_o  = (state_q == DONE); // Held until the next start
	assign state_o = state_q;

endmodule

//--- source/sample_addr_counter.sv
`timescale 1ns/1ps

module sample_addr_counter #(
	parameter int unsigned AddrWidth = 10,
	parameter int unsigned Decim     = 1
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 clear_i,
	input  logic                 run_i,
	input  logic                 sample_valid_i,
	output logic                 take_o,
	output logic                 last_o,
	output logic [AddrWidth-1:0] addr_o
);

	localparam int unsigned CaptureLen = 2 ** AddrWidth;
	localparam int unsigned PrescW     = (Decim > 1) ? $clog2(Decim) : 1;

	logic [PrescW-1:0]    presc_q;
	logic [AddrWidth-1:0] addr_q;

	// First valid sample after a clear is always taken
	assign take_o = run_i && sample_valid_i && (presc_q == '0);

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			presc_q <= '0;
			addr_q  <= '0;
		end else if (clear_i) begin
			presc_q <= '0;
			addr_q  <= '0;
		end else begin
			if (run_i && sample_valid_i) begin
				presc_q <= (presc_q == PrescW'(Decim - 1)) ? '0 : presc_q + 1'b1;
			end
			if (take_o) addr_q <= addr_q + 1'b1; // Wraps after the last word
		end
	end

	assign last_o = (addr_q == AddrWidth'(CaptureLen - 1));
	assign addr_o = addr_q;

endmodule

//--- sample_ram/sample_dpram_tlul.sv
`timescale 1ns/1ps

module sample_dpram_tlul
	import capture_pkg::*;
	import tlul_lite_pkg::*;
#(
	parameter int unsigned AddrWidth = DEPTH_LOG2
) (
	input  logic                 clk_i,

	// Sample write port
	input  logic                 sa_we_i,
	input  logic [AddrWidth-1:0] sa_addr_i,
	input  sample_t              sa_data_i,

	// Monitor read port
	input  logic                 rd_en_i,
	input  logic [AddrWidth-1:0] rd_addr_i,
	output sample_t              rd_data_o,

	// Bus word port
	input  logic                 bus_req_i,
	input  logic                 bus_we_i,
	input  logic [AddrWidth-1:0] bus_addr_i,
	input  logic [BUS_DW/8-1:0]  bus_wmask_i,
	input  logic [BUS_DW-1:0]    bus_wdata_i,
	output logic [BUS_DW-1:0]    bus_rdata_o
);

	localparam int unsigned CaptureLen = 2 ** AddrWidth;

	logic [BUS_DW-1:0] mem [CaptureLen];
	logic [BUS_DW-1:0] bus_rdata_q;
	sample_t           rd_data_q;

	// Both write ports share one process, the bridge keeps them apart in time
	always_ff @(posedge clk_i) begin
		if (sa_we_i) begin
			mem[sa_addr_i] <= BUS_DW'(sa_data_i); // Upper half stays zero
		end
		if (bus_req_i) begin
			if (bus_we_i) begin
				for (int b = 0; b < BUS_DW / 8; b++) begin
					if (bus_wmask_i[b]) mem[bus_addr_i][8*b +: 8] <= bus_wdata_i[8*b +: 8];
				end
			end else begin
				bus_rdata_q <= mem[bus_addr_i];
			end
		end
	end

	// Monitor read, a sample landing on the same word wins over the stored one
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			if (sa_we_i && (sa_addr_i == rd_addr_i)) begin
				rd_data_q <= sa_data_i;
			end else begin
				rd_data_q <= mem[rd_addr_i][$bits(sample_t)-1:0];
			end
		end
	end

	assign rd_data_o   = rd_data_q;
	assign bus_rdata_o = bus_rdata_q;

endmodule

//--- sample_ram/tlul_sram_bridge.sv
`timescale 1ns/1ps

module tlul_sram_bridge
	import tlul_lite_pkg::*;
#(
	parameter int unsigned AddrWidth = 10
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  tl_h2d_t              tl_i,
	output tl_d2h_t              tl_o,
	input  logic                 busy_i, // Sample port writes this cycle
	output logic                 bus_req_o,
	output logic                 bus_we_o,
	output logic [AddrWidth-1:0] bus_addr_o,
	output logic [BUS_DW/8-1:0]  bus_wmask_o,
	output logic [BUS_DW-1:0]    bus_wdata_o,
	input  logic [BUS_DW-1:0]    bus_rdata_i
);

	logic              ready_q;   // No response outstanding
	logic              d_valid_q;
	logic              capture_q; // RAM read data arrives this cycle
	tl_opcode_e        d_opcode_q;
	logic [BUS_DW-1:0] d_data_q;
	logic              accept;

	assign tl_o.a_ready = ready_q && !busy_i;
	assign accept       = tl_i.a_valid && tl_o.a_ready;

	// Request towards the RAM
	assign bus_req_o   = accept;
	assign bus_we_o    = (tl_i.a_opcode == PUT_FULL) || (tl_i.a_opcode == PUT_PARTIAL);
	assign bus_addr_o  = tl_i.a_address[AddrWidth+1:2]; // Byte to word index
	assign bus_wmask_o = (tl_i.a_opcode == PUT_FULL) ? '1 : tl_i.a_mask;
	assign bus_wdata_o = tl_i.a_data;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			ready_q   <= 1'b0;
			d_valid_q <= 1'b0;
			capture_q <= 1'b0;
		end else begin
			capture_q <= accept && !bus_we_o;
			if (accept) begin
				ready_q   <= 1'b0;
				d_valid_q <= 1'b1;
			end else if (!d_valid_q || tl_i.d_ready) begin
				ready_q   <= 1'b1;
				d_valid_q <= 1'b0;
			end
		end
	end

	// Response payload
	always_ff @(posedge clk_i) begin
		if (accept) begin
			d_opcode_q <= bus_we_o ? ACCESS_ACK : ACCESS_ACK_DATA;
			d_data_q   <= '0;
		end else if (capture_q) begin
			d_data_q <= bus_rdata_i;
		end
	end

	assign tl_o.d_valid  = d_valid_q;
	assign tl_o.d_opcode = d_opcode_q;
	assign tl_o.d_data   = capture_q ? bus_rdata_i : d_data_q; // Held after the first cycle

endmodule

//--- source/sample_capture_top.sv
`timescale 1ns/1ps

module sample_capture_top
	import capture_pkg::*;
	import tlul_lite_pkg::*;
#(
	parameter int unsigned AddrWidth = DEPTH_LOG2,
	parameter int unsigned Decim     = 4
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 start_i,
	input  logic                 sample_valid_i,
	input  sample_t              sample_data_i,
	input  logic                 rd_en_i,
	input  logic [AddrWidth-1:0] rd_addr_i,
	output sample_t              rd_data_o,
	input  tl_h2d_t              tl_i,
	output tl_d2h_t              tl_o,
	output logic                 done_o,
	output logic                 capturing_o
);

	logic                 clear;
	logic                 run;
	logic                 take;
	logic                 last;
	logic [AddrWidth-1:0] wr_addr;
	capture_state_e       state;

	logic                 bus_req;
	logic                 bus_we;
	logic [AddrWidth-1:0] bus_addr;
	logic [BUS_DW/8-1:0]  bus_wmask;
	logic [BUS_DW-1:0]    bus_wdata;
	logic [BUS_DW-1:0]    bus_rdata;

	capture_ctrl u_ctrl (
		.clk_i,
		.rst_ni,
		.start_i,
		.take_i  (take),
		.last_i  (last),
		.clear_o (clear),
		.run_o   (run),
		.done_o,
		.state_o (state)
	);

	sample_addr_counter #(
		.AddrWidth(AddrWidth),
		.Decim    (Decim)
	) u_counter (
		.clk_i,
		.rst_ni,
		.clear_i       (clear),
		.run_i         (run),
		.sample_valid_i,
		.take_o        (take),
		.last_o        (last),
		.addr_o        (wr_addr)
	);

	tlul_sram_bridge #(
		.AddrWidth(AddrWidth)
	) u_bridge (
		.clk_i,
		.rst_ni,
		.tl_i,
		.tl_o,
		.busy_i     (take), // Sample writes hold off the bus
		.bus_req_o  (bus_req),
		.bus_we_o   (bus_we),
		.bus_addr_o (bus_addr),
		.bus_wmask_o(bus_wmask),
		.bus_wdata_o(bus_wdata),
		.bus_rdata_i(bus_rdata)
	);

	sample_dpram_tlul #(
		.AddrWidth(AddrWidth)
	) u_ram (
		.clk_i,
		.sa_we_i    (take),
		.sa_addr_i  (wr_addr),
		.sa_data_i  (sample_data_i),
		.rd_en_i,
		.rd_addr_i,
		.rd_data_o,
		.bus_req_i  (bus_req),
		.bus_we_i   (bus_we),
		.bus_addr_i (bus_addr),
		.bus_wmask_i(bus_wmask),
		.bus_wdata_i(bus_wdata),
		.bus_rdata_o(bus_rdata)
	);

	assign capturing_o = run;

endmodule

//--- dv/sample_capture_properties.sv
`timescale 1ns/1ps

module sample_capture_properties
	import capture_pkg::*;
	import tlul_lite_pkg::*;
(
	input logic           clk_i,
	input logic           rst_ni,
	input tl_h2d_t        tl_i,
	input tl_d2h_t        tl_o,
	input logic           take_i,
	input logic           last_i,
	input logic           done_o,
	input capture_state_e state_i
);

	int unsigned assert_fails = 0; // Number of failed properties

	// After reset no response appears until a request is accepted
	d_valid_needs_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!tl_o.d_valid && !(tl_i.a_valid && tl_o.a_ready) |=> !tl_o.d_valid)
		else begin
			assert_fails++;
			$error("d_valid rose without an accepted request");
		end

	// Response is held under back-pressure
	d_hold_until_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
		tl_o.d_valid && !tl_i.d_ready |=>
		tl_o.d_valid && $stable(tl_o.d_opcode) && $stable(tl_o.d_data))
		else begin
			assert_fails++;
			$error("D channel response changed before d_ready");
		end

	a_ready_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
		tl_o.d_valid |-> !tl_o.a_ready)
		else begin
			assert_fails++;
			$error("a_ready high with a response pending");
		end

	// done_o only follows the final take of a running capture
	done_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(done_o) |-> $past(state_i == RUN && take_i && last_i))
		else begin
			assert_fails++;
			$error("done_o rose without a final take in RUN");
		end

endmodule

bind sample_capture_top sample_capture_properties u_props (
	.clk_i,
	.rst_ni,
	.tl_i,
	.tl_o,
	.take_i  (take),
	.last_i  (last),
	.done_o,
	.state_i (state)
);

//--- dv/sample_capture_tb.sv
`timescale 1ns/1ps

module sample_capture_tb
	import capture_pkg::*;
	import tlul_lite_pkg::*;
();

	localparam int unsigned AddrWidth  = 4;
	localparam int unsigned Decim      = 2;
	localparam int          NumWords   = 2 ** AddrWidth;
	localparam int          NumSamples = NumWords * Decim;
	localparam int          RecBase    = NumSamples; // Bus records follow the samples
	localparam int          BypassIdx  = 5 * Decim;  // Sample that lands on word 5
	localparam int          Timeout    = 200;

	logic                 clk_i = 1'b0;
	logic                 rst_ni;
	logic                 start_i;
	logic                 sample_valid_i;
	sample_t              sample_data_i;
	logic                 rd_en_i;
	logic [AddrWidth-1:0] rd_addr_i;
	sample_t              rd_data_o;
	tl_h2d_t              tl_i;
	tl_d2h_t              tl_o;
	logic                 done_o;
	logic                 capturing_o;

	logic [31:0]       patterns [NumSamples + 8];
	integer            seed = 72;
	int                errors = 0;
	int                tests = 0;
	int                errs_at_start = 0;
	int                sent_count = 0;
	bit                hung = 1'b0;
	tl_opcode_e        put_op;
	logic [BUS_DW-1:0] put_data;

	sample_capture_top #(
		.AddrWidth(AddrWidth),
		.Decim    (Decim)
	) u_dut (.*);

	always #50 clk_i = ~clk_i;

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [BUS_DW-1:0] got,
		input logic [BUS_DW-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_opcode(input string name, input tl_opcode_e got, input tl_opcode_e exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic end_test(input string title);
		tests++;
		$display("Test %0d %s: %s", tests, title, (errors == errs_at_start) ? "ok" : "failed");
		errs_at_start = errors;
	endtask

	task automatic start_capture();
		start_i = 1'b1;
		@(negedge clk_i);
		start_i = 1'b0;
	endtask

	// Stream order from the file, idle gaps of 0 to 2 cycles between samples
	task automatic stream_samples(input bit invert, input int bypass_idx);
		sample_t value;
		int      gap;
		sent_count = 0;
		for (int i = 0; i < NumSamples; i++) begin
			value = invert ? ~patterns[i][15:0] : patterns[i][15:0];
			sample_valid_i = 1'b1;
			sample_data_i  = value;
			if (i == bypass_idx) begin
				rd_en_i   = 1'b1;
				rd_addr_i = AddrWidth'(i / Decim); // Word being written now
			end
			sent_count = i + 1;
			@(negedge clk_i);
			sample_valid_i = 1'b0;
			if (i == bypass_idx) begin
				rd_en_i = 1'b0;
				check_sample("rd_data_o", rd_data_o, value);
			end
			gap = int'({$random(seed)} % 3);
			repeat (gap) @(negedge clk_i);
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done_o && cycles < Timeout) begin
			@(negedge clk_i);
			cycles++;
		end
		if (!done_o) begin
			$display("Timeout: done_o did not rise after the capture");
			hung = 1'b1;
		end
	endtask

	// One request, response held for a cycle before d_ready
	task automatic bus_access(input tl_opcode_e op, input logic [31:0] addr,
		input logic [BUS_DW-1:0] data, input logic [3:0] mask,
		output tl_opcode_e rsp_op, output logic [BUS_DW-1:0] rsp_data);
		int cycles;
		rsp_op         = ACCESS_ACK;
		rsp_data       = '0;
		tl_i.a_valid   = 1'b1;
		tl_i.a_opcode  = op;
		tl_i.a_address = addr;
		tl_i.a_data    = data;
		tl_i.a_mask    = mask;
		tl_i.d_ready   = 1'b0;
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
		end while (!tl_o.d_valid && cycles < Timeout);
		tl_i.a_valid = 1'b0;
		if (!tl_o.d_valid) begin
			$display("Timeout: no D channel response to the bus request");
			hung = 1'b1;
			return;
		end
		@(negedge clk_i);
		rsp_op       = tl_o.d_opcode;
		rsp_data     = tl_o.d_data;
		tl_i.d_ready = 1'b1;
		@(negedge clk_i);
		tl_i.d_ready = 1'b0;
	endtask

	task automatic get_and_check(input int word, input logic [BUS_DW-1:0] exp);
		tl_opcode_e        op;
		logic [BUS_DW-1:0] data;
		bus_access(GET, 32'(word * 4), '0, '0, op, data);
		check_opcode("d_opcode", op, ACCESS_ACK_DATA);
		check_word("d_data", data, exp);
	endtask

	initial begin
		rst_ni         = 1'b0;
		start_i        = 1'b0;
		sample_valid_i = 1'b0;
		sample_data_i  = '0;
		rd_en_i        = 1'b0;
		rd_addr_i      = '0;
		tl_i           = '0;
		$readmemh("dv/sample_patterns.hex", patterns);
		repeat (3) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);

		check_flag("done_o", done_o, 1'b0);
		check_flag("capturing_o", capturing_o, 1'b0);
		check_flag("d_valid", tl_o.d_valid, 1'b0);
		end_test("reset state");

		start_capture();
		check_flag("capturing_o", capturing_o, 1'b1);
		stream_samples(1'b0, -1);
		wait_done();
		for (int a = 0; a < NumWords; a++) begin
			rd_en_i   = 1'b1;
			rd_addr_i = AddrWidth'(a);
			@(negedge clk_i);
			rd_en_i = 1'b0;
			check_sample("rd_data_o", rd_data_o, patterns[a * Decim][15:0]);
		end
		end_test("capture and monitor readback");

		for (int w = 0; w < NumWords; w++) begin
			get_and_check(w, 32'(patterns[w * Decim][15:0])); // Zero-extended sample
		end
		end_test("bus read of captured words");

		bus_access(PUT_PARTIAL, patterns[RecBase], patterns[RecBase + 1],
			patterns[RecBase + 2][3:0], put_op, put_data);
		check_opcode("d_opcode", put_op, ACCESS_ACK);
		get_and_check(int'(patterns[RecBase] >> 2), patterns[RecBase + 3]);
		end_test("partial bus write of byte 1");

		start_capture();
		fork
			stream_samples(1'b1, BypassIdx);
			begin
				int cycles;
				cycles = 0;
				while (sent_count < 3 * Decim && cycles < Timeout) begin
					@(negedge clk_i);
					cycles++;
				end
				if (sent_count < 3 * Decim) begin
					$display("Timeout: sample stream did not start");
					hung = 1'b1;
				end
				bus_access(PUT_FULL, patterns[RecBase + 4], patterns[RecBase + 5],
					patterns[RecBase + 6][3:0], put_op, put_data);
				check_opcode("d_opcode", put_op, ACCESS_ACK);
			end
		join
		wait_done();
		end_test("monitor bypass during capture");

		get_and_check(int'(patterns[RecBase + 4] >> 2), patterns[RecBase + 7]);
		end_test("bus write while samples stream");

		$display("Tests %0d, errors %0d, assertion failures %0d, timeouts %0d",
			tests, errors, u_dut.u_props.assert_fails, hung);
		if (!hung && errors == 0 && u_dut.u_props.assert_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- dv/sample_patterns.hex
// Words 0 to 31: sample stream, two per line, the taken sample then the skipped one
// Words 32 to 39: two bus records of byte address, write data, mask, expected word
1a2b 0001
3c4d 0002
5e6f 0003
7081 0004
92a3 0005
b4c5 0006
d6e7 0007
f809 0008
1357 0009
2468 000a
9bdf 000b
ace0 000c
0f1e 000d
2d3c 000e
4b5a 000f
6978 0010
00000014 deadbeef 00000002 0000bec5
00000004 cafe0123 0000000f cafe0123

//--- verilog.f
common/capture_pkg.sv
common/tlul_lite_pkg.sv
source/capture_ctrl.sv
source/sample_addr_counter.sv
sample_ram/sample_dpram_tlul.sv
sample_ram/tlul_sram_bridge.sv
source/sample_capture_top.sv
dv/sample_capture_properties.sv
dv/sample_capture_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module sample_capture_tb -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vsample_capture_tb +verilator+error+limit+100)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1
